/* mips_core_stim.txt */
# P <byte addr> <instr> program word, D <byte addr> <word> initial RAM word
# E <byte addr> <data> expected store in program order
P 00 3C011234  # lui   $1, 0x1234
P 04 34215678  # ori   $1, $1, 0x5678
P 08 2422FFF8  # addiu $2, $1, -8
P 0C 00411823  # subu  $3, $2, $1
P 10 AC030100  # sw    $3, 0x100($0)
P 14 00232026  # xor   $4, $1, $3
P 18 0083282A  # slt   $5, $4, $3
P 1C 00A23025  # or    $6, $5, $2
P 20 AC040104  # sw    $4, 0x104($0)
P 24 AC050108  # sw    $5, 0x108($0)
P 28 AC06010C  # sw    $6, 0x10c($0)
P 2C 8C070080  # lw    $7, 0x80($0)
P 30 00E24021  # addu  $8, $7, $2   load-use
P 34 AC080110  # sw    $8, 0x110($0)
P 38 3C0ABAD0  # lui   $10, 0xbad0  marker
P 3C 24090001  # addiu $9, $0, 1
P 40 11250002  # beq   $9, $5, 0x4c taken
P 44 AC090114  # sw    $9, 0x114($0) delay slot
P 48 AC0A01F0  # sw    $10, 0x1f0($0) skipped
P 4C 8C0B0084  # lw    $11, 0x84($0)
P 50 15600003  # bne   $11, $0, 0x60 taken after stall
P 54 AC0B0118  # sw    $11, 0x118($0) delay slot
P 58 AC0A01F4  # sw    $10, 0x1f4($0) skipped
P 5C AC0A01F8  # sw    $10, 0x1f8($0) skipped
P 60 11600002  # beq   $11, $0, 0x6c not taken
P 64 256C0020  # addiu $12, $11, 0x20 delay slot
P 68 AC0C011C  # sw    $12, 0x11c($0) fall-through
P 6C 1000FFFF  # beq   $0, $0, 0x6c spin
P 70 00000000  # nop
D 80 00001234
D 84 FFFFFFF0
E 100 FFFFFFF8
E 104 EDCBA980
E 108 00000001
E 10C 12345671
E 110 123468A4
E 114 00000001
E 118 FFFFFFF0
E 11C 00000010

/* mips_core.f */
+incdir+.
mips_core_pkg.sv
fetch_stage.sv
decode_stage.sv
regfile.sv
execute_stage.sv
memory_stage.sv
mips_core.sv
tb_mips_core.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - include_dirs:
      - .
    files:
      - mips_core_pkg.sv
      - fetch_stage.sv
      - decode_stage.sv
      - regfile.sv
      - execute_stage.sv
      - memory_stage.sv
      - mips_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_mips_core.sv

/* tb_mips_core.sv */
`include "mips_core_macros.svh"
`default_nettype none

module tb_mips_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 8;
    localparam int TAIL_CYCLES  = 50;
    localparam int ROM_WORDS    = 64;
    localparam int RAM_WORDS    = 256;

    logic                  clk = 1'b0;
    logic                  arst_n;
    wire [`MIPS_XLEN-1:0]  rom_data;
    wire [`MIPS_XLEN-1:0]  ram_data;
    wire                   rom_ce;
    wire [`MIPS_XLEN-1:0]  rom_addr;
    wire                   ram_ce;
    wire                   ram_we;
    wire [`MIPS_XLEN-1:0]  ram_addr;
    wire [`MIPS_XLEN-1:0]  ram_wdata;

    logic [`MIPS_XLEN-1:0] rom [ROM_WORDS];
    logic [`MIPS_XLEN-1:0] ram [RAM_WORDS];
    logic [`MIPS_XLEN-1:0] exp_addr [$];
    logic [`MIPS_XLEN-1:0] exp_data [$];

    int prog_words      = 0;
    int watchdog_cycles = 0;
    int store_count     = 0;
    int value_errs      = 0;
    int other_errs      = 0;
    bit seen_fetch      = 1'b0;

    always #4 clk = ~clk;

    mips_core u_dut (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .rom_data_i  (rom_data),
        .ram_data_i  (ram_data),
        .rom_ce_o    (rom_ce),
        .rom_addr_o  (rom_addr),
        .ram_ce_o    (ram_ce),
        .ram_we_o    (ram_we),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata)
    );

    // memory answers settle 1 ns after the address moves
    assign #1 rom_data = rom[rom_addr[7:2]];
    assign #1 ram_data = ram[ram_addr[9:2]];

    always @(posedge clk) begin
        if (ram_ce === 1'b1 && ram_we === 1'b1) begin
            ram[ram_addr[9:2]] <= ram_wdata;
        end
    end

    function automatic bit addr_in_list(input logic [`MIPS_XLEN-1:0] addr);
        bit found;
        found = 1'b0;
        foreach (exp_addr[k]) begin
            if (exp_addr[k] == addr) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic print_counts();
        $display("errors: %0d value, %0d other, stores %0d of %0d",
                 value_errs, other_errs, store_count, exp_addr.size());
    endtask

    // P, D and E records with # comments
    task automatic load_stim(output bit ok);
        int                    fd;
        int                    n;
        int                    c;
        bit                    done;
        logic [7:0]            kind;
        logic [`MIPS_XLEN-1:0] a;
        logic [`MIPS_XLEN-1:0] d;
        done = 1'b0;
        fd   = $fopen("mips_core_stim.txt", "r");
        ok   = (fd != 0);
        if (ok) begin
            while (!done) begin
                n = $fscanf(fd, " %c", kind);
                if (n != 1) begin
                    done = 1'b1;
                end else if (kind == "#") begin
                    c = $fgetc(fd);
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else begin
                    n = $fscanf(fd, "%h %h", a, d);
                    case (kind)
                        "P": begin
                            rom[a[7:2]] = d;
                            prog_words++;
                        end
                        "D": ram[a[9:2]] = d;
                        "E": begin
                            exp_addr.push_back(a);
                            exp_data.push_back(d);
                        end
                        default: begin
                            other_errs++;
                            $display("stim file holds an unknown record type '%c'", kind);
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // reset strobes and first fetch address
    always @(negedge clk) begin
        if (!arst_n) begin
            if (rom_ce !== 1'b0 || ram_ce !== 1'b0 || ram_we !== 1'b0) begin
                value_errs++;
                $display("ERR %0t: strobe active in reset, rom_ce %b ram_ce %b ram_we %b",
                         $time, rom_ce, ram_ce, ram_we);
            end
        end else if (rom_ce === 1'b1 && !seen_fetch) begin
            seen_fetch = 1'b1;
            if (rom_addr !== `MIPS_RESET_PC) begin
                value_errs++;
                $display("ERR %0t: first fetch from %h, expected %h",
                         $time, rom_addr, `MIPS_RESET_PC);
            end
        end
    end

    // store held for the whole MEM cycle
    always @(negedge clk) begin
        if (arst_n && ram_ce === 1'b1 && ram_we === 1'b1) begin
            if (!addr_in_list(ram_addr)) begin
                value_errs++;
                $display("ERR %0t: store to unlisted address %h data %h",
                         $time, ram_addr, ram_wdata);
            end
            if (store_count >= exp_addr.size()) begin
                value_errs++;
                $display("ERR %0t: extra store %0d to %h", $time, store_count, ram_addr);
            end else if (ram_addr !== exp_addr[store_count] ||
                         ram_wdata !== exp_data[store_count]) begin
                value_errs++;
                $display("ERR %0t: store %0d got %h <= %h, expected %h <= %h",
                         $time, store_count, ram_addr, ram_wdata,
                         exp_addr[store_count], exp_data[store_count]);
            end
            store_count++;
        end
    end

    initial begin
        int unsigned seed;
        bit          loaded;
        arst_n = 1'b0;
        seed   = 32'h4e2bda75;
        seed   = $urandom(seed);
        for (int k = 0; k < ROM_WORDS; k++) begin
            rom[k] = '0;  // nop
        end
        for (int k = 0; k < RAM_WORDS; k++) begin
            ram[k] = $urandom();
        end
        load_stim(loaded);
        if (!loaded) begin
            $display("could not open mips_core_stim.txt");
            print_counts();
            $display("Test FAILED");
            $finish;
        end else begin
            watchdog_cycles = 20 * prog_words + 200;
            repeat (RESET_CYCLES) @(posedge clk);
            #1 arst_n = 1'b1;
            while (store_count < exp_addr.size()) begin
                @(posedge clk);
            end
            repeat (TAIL_CYCLES) @(posedge clk);
            if (!seen_fetch) begin
                other_errs++;
                $display("no instruction fetch was seen after reset");
            end
            if (store_count != exp_addr.size()) begin
                value_errs++;
                $display("ERR %0t: saw %0d stores, expected %0d",
                         $time, store_count, exp_addr.size());
            end
            print_counts();
            if (value_errs == 0 && other_errs == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("run timed out after %0d cycles with %0d of %0d stores seen",
                 watchdog_cycles, store_count, exp_addr.size());
        print_counts();
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* mips_core.sv */
`include "mips_core_macros.svh"
`default_nettype none

module mips_core (
    input  wire                   clk_i,
    input  wire                   arst_n_i,
    input  wire [`MIPS_XLEN-1:0]  rom_data_i,
    input  wire [`MIPS_XLEN-1:0]  ram_data_i,
    output wire                   rom_ce_o,
    output wire [`MIPS_XLEN-1:0]  rom_addr_o,
    output wire                   ram_ce_o,
    output wire                   ram_we_o,
    output wire [`MIPS_XLEN-1:0]  ram_addr_o,
    output wire [`MIPS_XLEN-1:0]  ram_wdata_o
);

    wire                      stall;
    wire                      branch_taken;
    wire [`MIPS_XLEN-1:0]     branch_target;

    wire [`MIPS_XLEN-1:0]     if_id_pc;
    mips_core_pkg::instr_u    if_id_instr;

    wire [`MIPS_REG_AW-1:0]   rs_addr;
    wire [`MIPS_REG_AW-1:0]   rt_addr;
    wire [`MIPS_XLEN-1:0]     rs_data;
    wire [`MIPS_XLEN-1:0]     rt_data;

    mips_core_pkg::alu_op_e   id_ex_op;
    wire [`MIPS_XLEN-1:0]     id_ex_a;
    wire [`MIPS_XLEN-1:0]     id_ex_b;
    wire [`MIPS_XLEN-1:0]     id_ex_store_data;
    wire [`MIPS_REG_AW-1:0]   id_ex_rd;
    wire                      id_ex_we;
    wire                      id_ex_load;
    wire                      id_ex_store;

    wire [`MIPS_REG_AW-1:0]   ex_rd;          // bypass and hazard view of EX
    wire                      ex_we;
    wire                      ex_is_load;
    wire [`MIPS_XLEN-1:0]     ex_result;

    wire [`MIPS_REG_AW-1:0]   ex_mem_rd;
    wire                      ex_mem_we;
    wire                      ex_mem_load;
    wire                      ex_mem_store;
    wire [`MIPS_XLEN-1:0]     ex_mem_result;
    wire [`MIPS_XLEN-1:0]     ex_mem_store_data;

    wire [`MIPS_REG_AW-1:0]   mem_rd;
    wire                      mem_we;
    wire [`MIPS_XLEN-1:0]     mem_data;
    wire [`MIPS_REG_AW-1:0]   wb_rd;
    wire                      wb_we;
    wire [`MIPS_XLEN-1:0]     wb_data;

    fetch_stage u_fetch (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .stall_i         (stall),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .rom_data_i      (rom_data_i),
        .rom_ce_o        (rom_ce_o),
        .pc_o            (rom_addr_o),
        .id_pc_o         (if_id_pc),
        .id_instr_o      (if_id_instr)
    );

    decode_stage u_decode (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .id_pc_i         (if_id_pc),
        .id_instr_i      (if_id_instr),
        .rs_data_i       (rs_data),
        .rt_data_i       (rt_data),
        .ex_rd_i         (ex_rd),
        .ex_is_load_i    (ex_is_load),
        .rs_addr_o       (rs_addr),
        .rt_addr_o       (rt_addr),
        .stall_o         (stall),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .ex_op_o         (id_ex_op),
        .ex_a_o          (id_ex_a),
        .ex_b_o          (id_ex_b),
        .ex_store_data_o (id_ex_store_data),
        .ex_rd_o         (id_ex_rd),
        .ex_we_o         (id_ex_we),
        .ex_load_o       (id_ex_load),
        .ex_store_o      (id_ex_store)
    );

    regfile u_regfile (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rs_addr_i  (rs_addr),
        .rt_addr_i  (rt_addr),
        .ex_rd_i    (ex_rd),
        .ex_we_i    (ex_we),
        .ex_data_i  (ex_result),
        .mem_rd_i   (mem_rd),
        .mem_we_i   (mem_we),
        .mem_data_i (mem_data),
        .wb_rd_i    (wb_rd),
        .wb_we_i    (wb_we),
        .wb_data_i  (wb_data),
        .rs_data_o  (rs_data),
        .rt_data_o  (rt_data)
    );

    execute_stage u_execute (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .op_i             (id_ex_op),
        .a_i              (id_ex_a),
        .b_i              (id_ex_b),
        .store_data_i     (id_ex_store_data),
        .rd_i             (id_ex_rd),
        .we_i             (id_ex_we),
        .load_i           (id_ex_load),
        .store_i          (id_ex_store),
        .rd_o             (ex_rd),
        .we_o             (ex_we),
        .is_load_o        (ex_is_load),
        .result_o         (ex_result),
        .mem_rd_o         (ex_mem_rd),
        .mem_we_o         (ex_mem_we),
        .mem_load_o       (ex_mem_load),
        .mem_store_o      (ex_mem_store),
        .mem_result_o     (ex_mem_result),
        .mem_store_data_o (ex_mem_store_data)
    );

    memory_stage u_memory (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .rd_i         (ex_mem_rd),
        .we_i         (ex_mem_we),
        .load_i       (ex_mem_load),
        .store_i      (ex_mem_store),
        .result_i     (ex_mem_result),
        .store_data_i (ex_mem_store_data),
        .ram_data_i   (ram_data_i),
        .ram_ce_o     (ram_ce_o),
        .ram_we_o     (ram_we_o),
        .ram_addr_o   (ram_addr_o),
        .ram_wdata_o  (ram_wdata_o),
        .rd_o         (mem_rd),
        .we_o         (mem_we),
        .data_o       (mem_data),
        .wb_rd_o      (wb_rd),
        .wb_we_o      (wb_we),
        .wb_data_o    (wb_data)
    );

endmodule

`default_nettype wire

/* memory_stage.sv */
`include "mips_core_macros.svh"
`default_nettype none

module memory_stage (
    input  wire                     clk_i,
    input  wire                     arst_n_i,
    input  wire [`MIPS_REG_AW-1:0]  rd_i,
    input  wire                     we_i,
    input  wire                     load_i,
    input  wire                     store_i,
    input  wire [`MIPS_XLEN-1:0]    result_i,
    input  wire [`MIPS_XLEN-1:0]    store_data_i,
    input  wire [`MIPS_XLEN-1:0]    ram_data_i,
    output logic                    ram_ce_o,
    output logic                    ram_we_o,
    output logic [`MIPS_XLEN-1:0]   ram_addr_o,
    output logic [`MIPS_XLEN-1:0]   ram_wdata_o,
    output logic [`MIPS_REG_AW-1:0] rd_o,
    output logic                    we_o,
    output logic [`MIPS_XLEN-1:0]   data_o,
    output logic [`MIPS_REG_AW-1:0] wb_rd_o,
    output logic                    wb_we_o,
    output logic [`MIPS_XLEN-1:0]   wb_data_o
);

    assign ram_ce_o    = load_i || store_i;
    assign ram_we_o    = store_i;
    assign ram_addr_o  = result_i;  // byte address from ALU
    assign ram_wdata_o = store_data_i;

    assign rd_o   = rd_i;
    assign we_o   = we_i;
    assign data_o = load_i ? ram_data_i : result_i;

    // MEM/WB
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_rd_o <= '0;
            wb_we_o <= 1'b0;
        end else begin
            wb_rd_o <= rd_i;
            wb_we_o <= we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_data_o <= data_o;
    end

endmodule

`default_nettype wire

/* execute_stage.sv */
`include "mips_core_macros.svh"
`default_nettype none

module execute_stage (
    input  wire                          clk_i,
    input  wire                          arst_n_i,
    input  mips_core_pkg::alu_op_e       op_i,
    input  wire [`MIPS_XLEN-1:0]         a_i,
    input  wire [`MIPS_XLEN-1:0]         b_i,
    input  wire [`MIPS_XLEN-1:0]         store_data_i,
    input  wire [`MIPS_REG_AW-1:0]       rd_i,
    input  wire                          we_i,
    input  wire                          load_i,
    input  wire                          store_i,
    output logic [`MIPS_REG_AW-1:0]      rd_o,
    output logic                         we_o,
    output logic                         is_load_o,
    output logic [`MIPS_XLEN-1:0]        result_o,
    output logic [`MIPS_REG_AW-1:0]      mem_rd_o,
    output logic                         mem_we_o,
    output logic                         mem_load_o,
    output logic                         mem_store_o,
    output logic [`MIPS_XLEN-1:0]        mem_result_o,
    output logic [`MIPS_XLEN-1:0]        mem_store_data_o
);

    always_comb begin
        case (op_i)
            mips_core_pkg::ALU_SUB: result_o = a_i - b_i;
            mips_core_pkg::ALU_AND: result_o = a_i & b_i;
            mips_core_pkg::ALU_OR:  result_o = a_i | b_i;
            mips_core_pkg::ALU_XOR: result_o = a_i ^ b_i;
            mips_core_pkg::ALU_SLT: result_o = `MIPS_XLEN'($signed(a_i) < $signed(b_i));
            mips_core_pkg::ALU_LUI: result_o = {b_i[15:0], 16'h0000};
            default:                result_o = a_i + b_i;  // also load/store address
        endcase
    end

    assign rd_o      = rd_i;
    assign we_o      = we_i && !load_i;  // load data not here yet
    assign is_load_o = load_i;

    // EX/MEM
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_rd_o    <= '0;
            mem_we_o    <= 1'b0;
            mem_load_o  <= 1'b0;
            mem_store_o <= 1'b0;
        end else begin
            mem_rd_o    <= rd_i;
            mem_we_o    <= we_i;
            mem_load_o  <= load_i;
            mem_store_o <= store_i;
        end
    end

    always_ff @(posedge clk_i) begin
        mem_result_o     <= result_o;
        mem_store_data_o <= store_data_i;
    end

endmodule

`default_nettype wire

/* regfile.sv */
`include "mips_core_macros.svh"
`default_nettype none

module regfile (
    input  wire                     clk_i,
    input  wire                     arst_n_i,
    input  wire [`MIPS_REG_AW-1:0]  rs_addr_i,
    input  wire [`MIPS_REG_AW-1:0]  rt_addr_i,
    input  wire [`MIPS_REG_AW-1:0]  ex_rd_i,
    input  wire                     ex_we_i,
    input  wire [`MIPS_XLEN-1:0]    ex_data_i,
    input  wire [`MIPS_REG_AW-1:0]  mem_rd_i,
    input  wire                     mem_we_i,
    input  wire [`MIPS_XLEN-1:0]    mem_data_i,
    input  wire [`MIPS_REG_AW-1:0]  wb_rd_i,
    input  wire                     wb_we_i,
    input  wire [`MIPS_XLEN-1:0]    wb_data_i,
    output logic [`MIPS_XLEN-1:0]   rs_data_o,
    output logic [`MIPS_XLEN-1:0]   rt_data_o
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

    // youngest producer first
    function automatic logic [`MIPS_XLEN-1:0] read_port(input logic [`MIPS_REG_AW-1:0] addr);
        logic [`MIPS_XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (ex_we_i && ex_rd_i == addr) begin
            value = ex_data_i;
        end else if (mem_we_i && mem_rd_i == addr) begin
            value = mem_data_i;
        end else if (wb_we_i && wb_rd_i == addr) begin
            value = wb_data_i;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs_data_o = read_port(rs_addr_i);
        rt_data_o = read_port(rt_addr_i);
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

endmodule

`default_nettype wire

/* decode_stage.sv */
`include "mips_core_macros.svh"
`default_nettype none

module decode_stage (
    input  wire                          clk_i,
    input  wire                          arst_n_i,
    input  wire [`MIPS_XLEN-1:0]         id_pc_i,
    input  mips_core_pkg::instr_u        id_instr_i,
    input  wire [`MIPS_XLEN-1:0]         rs_data_i,
    input  wire [`MIPS_XLEN-1:0]         rt_data_i,
    input  wire [`MIPS_REG_AW-1:0]       ex_rd_i,
    input  wire                          ex_is_load_i,
    output logic [`MIPS_REG_AW-1:0]      rs_addr_o,
    output logic [`MIPS_REG_AW-1:0]      rt_addr_o,
    output logic                         stall_o,
    output logic                         branch_taken_o,
    output logic [`MIPS_XLEN-1:0]        branch_target_o,
    output mips_core_pkg::alu_op_e       ex_op_o,
    output logic [`MIPS_XLEN-1:0]        ex_a_o,
    output logic [`MIPS_XLEN-1:0]        ex_b_o,
    output logic [`MIPS_XLEN-1:0]        ex_store_data_o,
    output logic [`MIPS_REG_AW-1:0]      ex_rd_o,
    output logic                         ex_we_o,
    output logic                         ex_load_o,
    output logic                         ex_store_o
);

    logic [5:0]              opcode;
    logic [`MIPS_XLEN-1:0]   imm_sext;
    logic [`MIPS_XLEN-1:0]   imm_zext;
    mips_core_pkg::alu_op_e  alu_op;
    logic [`MIPS_XLEN-1:0]   operand_b;
    logic [`MIPS_REG_AW-1:0] dest;
    logic                    dest_we;
    logic                    is_load;
    logic                    is_store;
    logic                    is_branch;
    logic                    uses_rs;
    logic                    uses_rt;
    logic                    operands_eq;

    assign opcode    = id_instr_i.r.op;
    assign rs_addr_o = id_instr_i.r.rs;
    assign rt_addr_o = id_instr_i.i.rt;
    assign imm_sext  = {{(`MIPS_XLEN-16){id_instr_i.i.imm[15]}}, id_instr_i.i.imm};
    assign imm_zext  = {{(`MIPS_XLEN-16){1'b0}}, id_instr_i.i.imm};

    always_comb begin
        alu_op    = mips_core_pkg::ALU_ADD;
        operand_b = rt_data_i;
        dest      = id_instr_i.i.rt;  // I-type writes rt
        dest_we   = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        uses_rs   = 1'b0;
        uses_rt   = 1'b0;
        case (opcode)
            `MIPS_OP_SPECIAL: begin
                dest    = id_instr_i.r.rd;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                dest_we = 1'b1;
                case (id_instr_i.r.funct)
                    `MIPS_FN_ADDU: alu_op = mips_core_pkg::ALU_ADD;
                    `MIPS_FN_SUBU: alu_op = mips_core_pkg::ALU_SUB;
                    `MIPS_FN_AND:  alu_op = mips_core_pkg::ALU_AND;
                    `MIPS_FN_OR:   alu_op = mips_core_pkg::ALU_OR;
                    `MIPS_FN_XOR:  alu_op = mips_core_pkg::ALU_XOR;
                    `MIPS_FN_SLT:  alu_op = mips_core_pkg::ALU_SLT;
                    default:       dest_we = 1'b0;  // nop and unsupported
                endcase
            end
            `MIPS_OP_ADDIU: begin
                operand_b = imm_sext;
                dest_we   = 1'b1;
                uses_rs   = 1'b1;
            end
            `MIPS_OP_ORI: begin
                alu_op    = mips_core_pkg::ALU_OR;
                operand_b = imm_zext;
                dest_we   = 1'b1;
                uses_rs   = 1'b1;
            end
            `MIPS_OP_LUI: begin
                alu_op    = mips_core_pkg::ALU_LUI;
                operand_b = imm_zext;
                dest_we   = 1'b1;
            end
            `MIPS_OP_LW: begin
                operand_b = imm_sext;
                dest_we   = 1'b1;
                is_load   = 1'b1;
                uses_rs   = 1'b1;
            end
            `MIPS_OP_SW: begin
                operand_b = imm_sext;
                is_store  = 1'b1;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
            end
            `MIPS_OP_BEQ, `MIPS_OP_BNE: begin
                is_branch = 1'b1;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
            end
            default: ;
        endcase
    end

    // load result not ready until MEM
    assign stall_o = ex_is_load_i && (ex_rd_i != '0) &&
                     ((uses_rs && rs_addr_o == ex_rd_i) || (uses_rt && rt_addr_o == ex_rd_i));

    assign operands_eq     = (rs_data_i == rt_data_i);
    assign branch_taken_o  = is_branch && !stall_o &&
                             (operands_eq != (opcode == `MIPS_OP_BNE));
    assign branch_target_o = id_pc_i + `MIPS_XLEN'(4) + {imm_sext[`MIPS_XLEN-3:0], 2'b00};

    // ID/EX control
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_rd_o    <= '0;
            ex_we_o    <= 1'b0;
            ex_load_o  <= 1'b0;
            ex_store_o <= 1'b0;
        end else if (stall_o) begin  // bubble
            ex_rd_o    <= '0;
            ex_we_o    <= 1'b0;
            ex_load_o  <= 1'b0;
            ex_store_o <= 1'b0;
        end else begin
            ex_rd_o    <= dest;
            ex_we_o    <= dest_we;
            ex_load_o  <= is_load;
            ex_store_o <= is_store;
        end
    end

    always_ff @(posedge clk_i) begin
        ex_op_o         <= alu_op;
        ex_a_o          <= rs_data_i;
        ex_b_o          <= operand_b;
        ex_store_data_o <= rt_data_i;
    end

endmodule

`default_nettype wire

/* fetch_stage.sv */
`include "mips_core_macros.svh"
`default_nettype none

module fetch_stage (
    input  wire                          clk_i,
    input  wire                          arst_n_i,
    input  wire                          stall_i,
    input  wire                          branch_taken_i,
    input  wire [`MIPS_XLEN-1:0]         branch_target_i,
    input  wire [`MIPS_XLEN-1:0]         rom_data_i,
    output logic                         rom_ce_o,
    output logic [`MIPS_XLEN-1:0]        pc_o,
    output logic [`MIPS_XLEN-1:0]        id_pc_o,
    output mips_core_pkg::instr_u        id_instr_o
);

    logic [`MIPS_XLEN-1:0] pc_next;

    // redirect wins over the sequential step
    assign pc_next = branch_taken_i ? branch_target_i : pc_o + `MIPS_XLEN'(4);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rom_ce_o <= 1'b0;
            pc_o     <= `MIPS_RESET_PC;
        end else begin
            rom_ce_o <= 1'b1;
            if (rom_ce_o && !stall_i) begin
                pc_o <= pc_next;
            end
        end
    end

    // IF/ID register
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_pc_o    <= '0;
            id_instr_o <= '0;  // all-zero word is a nop
        end else if (rom_ce_o && !stall_i) begin
            id_pc_o    <= pc_o;
            id_instr_o <= rom_data_i;
        end
    end

endmodule

`default_nettype wire

/* mips_core_pkg.sv */
`include "mips_core_macros.svh"
`default_nettype none

package mips_core_pkg;

    typedef struct packed {
        logic [5:0]              op;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [`MIPS_REG_AW-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } r_type_t;

    typedef struct packed {
        logic [5:0]              op;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [15:0]             imm;
    } i_type_t;

    // two field layouts of one instruction word
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

endpackage

`default_nettype wire

/* mips_core_macros.svh */
`ifndef MIPS_CORE_MACROS_SVH
`define MIPS_CORE_MACROS_SVH

`define MIPS_XLEN     32
`define MIPS_REG_AW   5
`define MIPS_NREGS    32
`define MIPS_RESET_PC 32'h0000_0000

// primary opcodes
`define MIPS_OP_SPECIAL 6'b000000
`define MIPS_OP_BEQ     6'b000100
`define MIPS_OP_BNE     6'b000101
`define MIPS_OP_ADDIU   6'b001001
`define MIPS_OP_ORI     6'b001101
`define MIPS_OP_LUI     6'b001111
`define MIPS_OP_LW      6'b100011
`define MIPS_OP_SW      6'b101011

// funct codes under SPECIAL
`define MIPS_FN_ADDU 6'b100001
`define MIPS_FN_SUBU 6'b100011
`define MIPS_FN_AND  6'b100100
`define MIPS_FN_OR   6'b100101
`define MIPS_FN_XOR  6'b100110
`define MIPS_FN_SLT  6'b101010

`endif
